//--- verilog/controlPkg.sv
package controlPkg;

	// Opcode field, insBits[4:0] = instruction bits 6:2
	localparam logic [4:0] opcR      = 5'b01100;
	localparam logic [4:0] opcI      = 5'b00100;
	localparam logic [4:0] opcLoad   = 5'b00000;
	localparam logic [4:0] opcStore  = 5'b01000;
	localparam logic [4:0] opcBranch = 5'b11000;
	localparam logic [4:0] opcJal    = 5'b11011;
	localparam logic [4:0] opcJalr   = 5'b11001;
	localparam logic [4:0] opcLui    = 5'b01101;
	localparam logic [4:0] opcAuipc  = 5'b00101;

	typedef enum logic [3:0] {
		classR,
		classI,
		classLoad,
		classStore,
		classBranch,
		classJal,
		classJalr,
		classLui,
		classAuipc,
		classIllegal
	} opClassT;

	// Codes as the ALU expects them, 1000 is unused
	typedef enum logic [3:0] {
		aluAdd  = 4'b0000,
		aluSub  = 4'b0001,
		aluAnd  = 4'b0010,
		aluOr   = 4'b0011,
		aluXor  = 4'b0100,
		aluSll  = 4'b0101,
		aluSrl  = 4'b0110,
		aluSra  = 4'b0111,
		aluSlt  = 4'b1001,
		aluSltu = 4'b1010
	} aluOpT;

	typedef enum logic [2:0] {
		immNone   = 3'b000,
		immUpper  = 3'b001, // 20-bit upper immediate
		immItype  = 3'b010,
		immShamt  = 3'b011, // 5-bit shift amount
		immBranch = 3'b100,
		immStore  = 3'b101,
		immJump   = 3'b110
	} immKindT;

	typedef enum logic [2:0] {
		loadWord  = 3'b000,
		loadHalf  = 3'b001,
		loadByte  = 3'b010,
		loadHalfU = 3'b011,
		loadByteU = 3'b100
	} loadKindT;

	typedef enum logic [1:0] {
		storeWord = 2'b00,
		storeHalf = 2'b01,
		storeByte = 2'b10
	} storeKindT;

	typedef enum logic [1:0] {
		wbMem = 2'b00,
		wbAlu = 2'b01,
		wbPc  = 2'b10 // Link address PC + 4
	} wbSelT;

	typedef enum logic {pcNext = 1'b0, pcAlu = 1'b1} pcSelT;
	typedef enum logic {aReg = 1'b0, aPc = 1'b1} aSelT;
	typedef enum logic {bReg = 1'b0, bImm = 1'b1} bSelT;

endpackage

//--- verilog/operandDecode.sv
`timescale 1ns/100ps

module operandDecode (
	input  controlPkg::opClassT opClass,
	input  logic [2:0]          funct3,
	input  logic                funct7b5,
	output controlPkg::aluOpT   aluOp,
	output controlPkg::immKindT immKind,
	output controlPkg::aSelT    aSel,
	output controlPkg::bSelT    bSel,
	output logic                legal
);

	// Shared funct3 map of the R and I groups
	function automatic controlPkg::aluOpT aluFromFunct3(
		input logic [2:0] f3,
		input logic       f7b5,
		input logic       isReg
	);
		controlPkg::aluOpT op;
		case (f3)
			3'b000: op = (isReg && f7b5) ? controlPkg::aluSub : controlPkg::aluAdd;
			3'b001: op = controlPkg::aluSll;
			3'b010: op = controlPkg::aluSlt;
			3'b011: op = controlPkg::aluSltu;
			3'b100: op = controlPkg::aluXor;
			3'b101: op = f7b5 ? controlPkg::aluSra : controlPkg::aluSrl; // Both groups
			3'b110: op = controlPkg::aluOr;
			default: op = controlPkg::aluAnd;
		endcase
		return op;
	endfunction

	always_comb begin
		aluOp = controlPkg::aluAdd; // Address and link sums
		immKind = controlPkg::immNone;
		aSel = controlPkg::aReg;
		bSel = controlPkg::bReg;
		legal = 1'b1;
		case (opClass)
			controlPkg::classR: aluOp = aluFromFunct3(funct3, funct7b5, 1'b1);
			controlPkg::classI: begin
				aluOp = aluFromFunct3(funct3, funct7b5, 1'b0);
				bSel = controlPkg::bImm;
				if (funct3 == 3'b001 || funct3 == 3'b101) begin
					immKind = controlPkg::immShamt;
				end else begin
					immKind = controlPkg::immItype;
				end
			end
			controlPkg::classLoad: begin
				immKind = controlPkg::immItype;
				bSel = controlPkg::bImm;
				legal = funct3 != 3'b011 && funct3 < 3'b110; // LB LH LW LBU LHU
			end
			controlPkg::classStore: begin
				immKind = controlPkg::immStore;
				bSel = controlPkg::bImm;
				legal = funct3 <= 3'b010;
			end
			controlPkg::classBranch: begin
				immKind = controlPkg::immBranch;
				legal = funct3[2:1] != 2'b01;
			end
			controlPkg::classJal: begin
				immKind = controlPkg::immJump;
				aSel = controlPkg::aPc;
				bSel = controlPkg::bImm;
			end
			controlPkg::classJalr: begin
				immKind = controlPkg::immItype;
				bSel = controlPkg::bImm;
			end
			controlPkg::classLui: begin
				immKind = controlPkg::immUpper;
				bSel = controlPkg::bImm;
			end
			controlPkg::classAuipc: begin
				immKind = controlPkg::immUpper;
				aSel = controlPkg::aPc;
				bSel = controlPkg::bImm;
			end
			default: legal = 1'b0;
		endcase
		if (!legal) begin // Back to the inactive word
			aluOp = controlPkg::aluAdd;
			immKind = controlPkg::immNone;
			aSel = controlPkg::aReg;
			bSel = controlPkg::bReg;
		end
	end

endmodule

//--- verilog/memWbDecode.sv
`timescale 1ns/100ps

module memWbDecode (
	input  controlPkg::opClassT   opClass,
	input  logic [2:0]            funct3,
	input  logic                  legal,
	output controlPkg::loadKindT  loadKind,
	output controlPkg::storeKindT storeKind,
	output logic                  memWrite,
	output logic                  regWEn,
	output controlPkg::wbSelT     wbSel
);

	always_comb begin
		loadKind = controlPkg::loadWord;
		storeKind = controlPkg::storeWord;
		memWrite = 1'b0;
		regWEn = 1'b0;
		wbSel = controlPkg::wbMem;
		if (legal) begin
			case (opClass)
				controlPkg::classLoad: begin
					regWEn = 1'b1;
					case (funct3)
						3'b000: loadKind = controlPkg::loadByte;
						3'b001: loadKind = controlPkg::loadHalf;
						3'b100: loadKind = controlPkg::loadByteU;
						3'b101: loadKind = controlPkg::loadHalfU;
						default: loadKind = controlPkg::loadWord;
					endcase
				end
				controlPkg::classStore: begin
					memWrite = 1'b1;
					wbSel = controlPkg::wbAlu;
					case (funct3)
						3'b000: storeKind = controlPkg::storeByte; // Own code, no longer SW's
						3'b001: storeKind = controlPkg::storeHalf;
						default: storeKind = controlPkg::storeWord;
					endcase
				end
				controlPkg::classJal, controlPkg::classJalr: begin
					regWEn = 1'b1;
					wbSel = controlPkg::wbPc;
				end
				controlPkg::classBranch: wbSel = controlPkg::wbAlu; // No register write
				default: begin // R, I, LUI, AUIPC
					regWEn = 1'b1;
					wbSel = controlPkg::wbAlu;
				end
			endcase
		end
	end

endmodule

//--- verilog/branchResolve.sv
`timescale 1ns/100ps

module branchResolve (
	input  controlPkg::opClassT opClass,
	input  logic [2:0]          funct3,
	input  logic                brEq,
	input  logic                brLt,
	output controlPkg::pcSelT   pcSel,
	output logic                brUnsigned
);

	logic taken;

	// Flags come back from the comparator in this same cycle
	always_comb begin
		taken = 1'b0;
		brUnsigned = 1'b0;
		case (opClass)
			controlPkg::classBranch: begin
				brUnsigned = funct3[2:1] == 2'b11; // BLTU BGEU
				case (funct3)
					3'b000: taken = brEq;
					3'b001: taken = !brEq;
					3'b100, 3'b110: taken = brLt;
					3'b101, 3'b111: taken = !brLt;
					default: taken = 1'b0;
				endcase
			end
			controlPkg::classJal, controlPkg::classJalr: taken = 1'b1;
			default: taken = 1'b0;
		endcase
	end

	assign pcSel = taken ? controlPkg::pcAlu : controlPkg::pcNext;

endmodule

//--- verilog/controlUnit.sv
`timescale 1ns/100ps

module controlUnit (
	input  logic                  clk,
	input  logic                  rstN,
	input  logic                  insValid,
	input  logic [8:0]            insBits,
	input  logic                  brEq,
	input  logic                  brLt,
	output logic                  ctlValid,
	output controlPkg::pcSelT     pcSel,
	output logic                  brUnsigned,
	output controlPkg::immKindT   immKind,
	output controlPkg::aSelT      aSel,
	output controlPkg::bSelT      bSel,
	output controlPkg::aluOpT     aluOp,
	output logic                  memWrite,
	output controlPkg::storeKindT storeKind,
	output controlPkg::loadKindT  loadKind,
	output logic                  regWEn,
	output controlPkg::wbSelT     wbSel
);

	logic                  funct7b5;
	logic [2:0]            funct3;
	logic [4:0]            opcode;
	controlPkg::opClassT   opClass;
	logic                  legal;
	controlPkg::pcSelT     decPcSel;
	controlPkg::immKindT   decImmKind;
	controlPkg::aSelT      decASel;
	controlPkg::bSelT      decBSel;
	controlPkg::aluOpT     decAluOp;
	logic                  decMemWrite;
	controlPkg::storeKindT decStoreKind;
	controlPkg::loadKindT  decLoadKind;
	logic                  decRegWEn;
	controlPkg::wbSelT     decWbSel;

	assign funct7b5 = insBits[8];
	assign funct3 = insBits[7:5];
	assign opcode = insBits[4:0];

	always_comb begin
		case (opcode)
			controlPkg::opcR: opClass = controlPkg::classR;
			controlPkg::opcI: opClass = controlPkg::classI;
			controlPkg::opcLoad: opClass = controlPkg::classLoad;
			controlPkg::opcStore: opClass = controlPkg::classStore;
			controlPkg::opcBranch: opClass = controlPkg::classBranch;
			controlPkg::opcJal: opClass = controlPkg::classJal;
			controlPkg::opcJalr: opClass = controlPkg::classJalr;
			controlPkg::opcLui: opClass = controlPkg::classLui;
			controlPkg::opcAuipc: opClass = controlPkg::classAuipc;
			default: opClass = controlPkg::classIllegal;
		endcase
	end

	operandDecode operandDec0 (
		.opClass  (opClass),
		.funct3   (funct3),
		.funct7b5 (funct7b5),
		.aluOp    (decAluOp),
		.immKind  (decImmKind),
		.aSel     (decASel),
		.bSel     (decBSel),
		.legal    (legal)
	);

	memWbDecode memWbDec0 (
		.opClass   (opClass),
		.funct3    (funct3),
		.legal     (legal),
		.loadKind  (decLoadKind),
		.storeKind (decStoreKind),
		.memWrite  (decMemWrite),
		.regWEn    (decRegWEn),
		.wbSel     (decWbSel)
	);

	branchResolve branchRes0 (
		.opClass    (opClass),
		.funct3     (funct3),
		.brEq       (brEq),
		.brLt       (brLt),
		.pcSel      (decPcSel),
		.brUnsigned (brUnsigned) // Straight out to the comparator
	);

	always_ff @(posedge clk) begin
		if (!rstN || !insValid) begin // Inactive word
			ctlValid <= 1'b0;
			pcSel <= controlPkg::pcNext;
			immKind <= controlPkg::immNone;
			aSel <= controlPkg::aReg;
			bSel <= controlPkg::bReg;
			aluOp <= controlPkg::aluAdd;
			memWrite <= 1'b0;
			storeKind <= controlPkg::storeWord;
			loadKind <= controlPkg::loadWord;
			regWEn <= 1'b0;
			wbSel <= controlPkg::wbMem;
		end else begin
			ctlValid <= 1'b1;
			pcSel <= decPcSel;
			immKind <= decImmKind;
			aSel <= decASel;
			bSel <= decBSel;
			aluOp <= decAluOp;
			memWrite <= decMemWrite;
			storeKind <= decStoreKind;
			loadKind <= decLoadKind;
			regWEn <= decRegWEn;
			wbSel <= decWbSel;
		end
	end

	noStoreAndWrite: assert property (@(posedge clk) disable iff (!rstN)
		!(memWrite && regWEn)) else $error("memWrite and regWEn both high");

	idleIsQuiet: assert property (@(posedge clk) disable iff (!rstN)
		!ctlValid |-> !memWrite && !regWEn) else $error("Side effect without ctlValid");

endmodule

//--- testbench/controlRef.svh
`ifndef CONTROL_REF_SVH
`define CONTROL_REF_SVH

typedef struct packed {
	logic       ctlValid;
	logic       pcSel;
	logic       brUnsigned; // Combinational, not part of the register
	logic [2:0] immKind;
	logic       aSel;
	logic       bSel;
	logic [3:0] aluOp;
	logic       memWrite;
	logic [1:0] storeKind;
	logic [2:0] loadKind;
	logic       regWEn;
	logic [1:0] wbSel;
} ctlWordT;

// Expected word for a valid instruction key and comparator flags
function automatic ctlWordT refDecode(input logic [8:0] ins, input logic eq, input logic lt);
	ctlWordT w;
	logic [2:0] f3;
	logic [3:0] alu;
	logic ok;
	f3 = ins[7:5];
	w = '0; // Every field at its inactive value
	w.ctlValid = 1'b1;
	ok = 1'b1;
	case (f3)
		3'b000: alu = controlPkg::aluAdd;
		3'b001: alu = controlPkg::aluSll;
		3'b010: alu = controlPkg::aluSlt;
		3'b011: alu = controlPkg::aluSltu;
		3'b100: alu = controlPkg::aluXor; // XOR and XORI
		3'b101: alu = ins[8] ? controlPkg::aluSra : controlPkg::aluSrl;
		3'b110: alu = controlPkg::aluOr;
		default: alu = controlPkg::aluAnd; // ANDI on 111
	endcase
	case (ins[4:0])
		controlPkg::opcR: begin
			w.aluOp = (f3 == 3'b000 && ins[8]) ? controlPkg::aluSub : alu;
			w.regWEn = 1'b1;
			w.wbSel = controlPkg::wbAlu;
		end
		controlPkg::opcI: begin
			w.aluOp = alu;
			w.immKind = (f3[1:0] == 2'b01) ? controlPkg::immShamt : controlPkg::immItype;
			w.bSel = controlPkg::bImm;
			w.regWEn = 1'b1;
			w.wbSel = controlPkg::wbAlu;
		end
		controlPkg::opcLoad: begin
			ok = f3 != 3'b011 && f3 != 3'b110 && f3 != 3'b111;
			w.immKind = controlPkg::immItype;
			w.bSel = controlPkg::bImm;
			w.regWEn = 1'b1;
			case (f3)
				3'b000: w.loadKind = controlPkg::loadByte;
				3'b001: w.loadKind = controlPkg::loadHalf;
				3'b100: w.loadKind = controlPkg::loadByteU;
				3'b101: w.loadKind = controlPkg::loadHalfU;
				default: w.loadKind = controlPkg::loadWord;
			endcase
		end
		controlPkg::opcStore: begin
			ok = !f3[2] && f3 != 3'b011;
			w.immKind = controlPkg::immStore;
			w.bSel = controlPkg::bImm;
			w.memWrite = 1'b1;
			w.wbSel = controlPkg::wbAlu;
			if (f3 == 3'b000) begin
				w.storeKind = controlPkg::storeByte;
			end else if (f3 == 3'b001) begin
				w.storeKind = controlPkg::storeHalf;
			end
		end
		controlPkg::opcBranch: begin
			ok = f3[2] || !f3[1];
			w.immKind = controlPkg::immBranch;
			w.wbSel = controlPkg::wbAlu;
			w.brUnsigned = f3[2] && f3[1];
			w.pcSel = f3[2] ? (lt ^ f3[0]) : (eq ^ f3[0]); // Odd funct3 inverts the test
		end
		controlPkg::opcJal, controlPkg::opcJalr: begin
			w.pcSel = controlPkg::pcAlu;
			w.immKind = ins[1] ? controlPkg::immJump : controlPkg::immItype; // JAL vs JALR
			w.aSel = ins[1] ? controlPkg::aPc : controlPkg::aReg;
			w.bSel = controlPkg::bImm;
			w.regWEn = 1'b1;
			w.wbSel = controlPkg::wbPc;
		end
		controlPkg::opcLui, controlPkg::opcAuipc: begin
			w.immKind = controlPkg::immUpper;
			w.aSel = ins[3] ? controlPkg::aReg : controlPkg::aPc; // LUI has bit 3 set
			w.bSel = controlPkg::bImm;
			w.regWEn = 1'b1;
			w.wbSel = controlPkg::wbAlu;
		end
		default: ok = 1'b0;
	endcase
	if (!ok) begin
		w = '0;
		w.ctlValid = 1'b1;
	end
	return w;
endfunction

`endif

//--- testbench/controlUnitTb.sv
`timescale 1ns/100ps

module controlUnitTb;

	`include "controlRef.svh"

	localparam int maxCycles = 2500; // About 2250 cycles of tests plus margin

	logic clk = 1'b0;
	logic rstN;
	logic insValid;
	logic [8:0] insBits;
	logic brEq;
	logic brLt;
	logic ctlValid;
	controlPkg::pcSelT pcSel;
	logic brUnsigned;
	controlPkg::immKindT immKind;
	controlPkg::aSelT aSel;
	controlPkg::bSelT bSel;
	controlPkg::aluOpT aluOp;
	logic memWrite;
	controlPkg::storeKindT storeKind;
	controlPkg::loadKindT loadKind;
	logic regWEn;
	controlPkg::wbSelT wbSel;

	ctlWordT expQ[$];
	ctlWordT expWord;
	ctlWordT actWord;
	ctlWordT combWord;
	logic [4:0] knownOpc [0:8];
	int errCount = 0;
	int errMark = 0;
	int checkCount = 0;
	int testNum = 1;
	int wordsIn = 0;
	int wordsOut = 0;
	int cycles = 0;

	controlUnit dut0 (
		.clk        (clk),
		.rstN       (rstN),
		.insValid   (insValid),
		.insBits    (insBits),
		.brEq       (brEq),
		.brLt       (brLt),
		.ctlValid   (ctlValid),
		.pcSel      (pcSel),
		.brUnsigned (brUnsigned),
		.immKind    (immKind),
		.aSel       (aSel),
		.bSel       (bSel),
		.aluOp      (aluOp),
		.memWrite   (memWrite),
		.storeKind  (storeKind),
		.loadKind   (loadKind),
		.regWEn     (regWEn),
		.wbSel      (wbSel)
	);

	always #20 clk = ~clk;

	task automatic checkValue(input string name, input logic [31:0] expVal,
		input logic [31:0] actVal);
		checkCount++;
		if (expVal !== actVal) begin
			errCount++;
			$display("FAILED at %0t ns: %s expected %0h, got %0h", $time, name, expVal, actVal);
		end
	endtask

	// Registered outputs still hold last cycle's word here
	always @(posedge clk) begin
		combWord = refDecode(insBits, brEq, brLt);
		checkValue("brUnsigned", combWord.brUnsigned, brUnsigned);
		if (expQ.size() > 0) begin
			expWord = expQ.pop_front();
			actWord = {ctlValid, pcSel, 1'b0, immKind, aSel, bSel, aluOp, memWrite,
				storeKind, loadKind, regWEn, wbSel};
			checkValue("ctlValid", expWord.ctlValid, actWord.ctlValid);
			checkValue("pcSel", expWord.pcSel, actWord.pcSel);
			checkValue("immKind", expWord.immKind, actWord.immKind);
			checkValue("aSel", expWord.aSel, actWord.aSel);
			checkValue("bSel", expWord.bSel, actWord.bSel);
			checkValue("aluOp", expWord.aluOp, actWord.aluOp);
			checkValue("memWrite", expWord.memWrite, actWord.memWrite);
			checkValue("storeKind", expWord.storeKind, actWord.storeKind);
			checkValue("loadKind", expWord.loadKind, actWord.loadKind);
			checkValue("regWEn", expWord.regWEn, actWord.regWEn);
			checkValue("wbSel", expWord.wbSel, actWord.wbSel);
		end
		if (ctlValid === 1'b1) begin
			wordsOut++;
		end
		if (rstN && insValid) begin
			combWord.brUnsigned = 1'b0;
			expQ.push_back(combWord);
			wordsIn++;
		end else begin
			expQ.push_back('0); // Inactive word
		end
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles >= maxCycles) begin
			$display("Timeout: run still busy after %0d cycles", maxCycles);
			$display("Verification failed");
			$finish;
		end
	end

	task automatic driveIns(input logic v, input logic [8:0] bits, input logic eq,
		input logic lt);
		@(negedge clk);
		insValid = v;
		insBits = bits;
		brEq = eq;
		brLt = lt;
	endtask

	task automatic endTest(input string name);
		repeat (2) driveIns(1'b0, 9'h000, 1'b0, 1'b0); // Drain the last word
		$display("Test %0d %s: %0d errors", testNum, name, errCount - errMark);
		testNum++;
		errMark = errCount;
	endtask

	// Every funct7b5 and funct3 of one opcode
	task automatic sweepOpcode(input logic [4:0] opc, input bit allFlags);
		logic [31:0] rnd;
		for (int k = 0; k < 16; k++) begin
			if (allFlags) begin
				for (int f = 0; f < 4; f++) begin
					driveIns(1'b1, {k[3:0], opc}, f[1], f[0]);
				end
			end else begin
				rnd = $urandom;
				driveIns(1'b1, {k[3:0], opc}, rnd[1], rnd[0]);
			end
		end
	endtask

	initial begin
		logic [31:0] rnd;
		logic known;
		void'($urandom(32'h26b8_ce56));
		knownOpc = '{controlPkg::opcR, controlPkg::opcI, controlPkg::opcLoad,
			controlPkg::opcStore, controlPkg::opcBranch, controlPkg::opcJal,
			controlPkg::opcJalr, controlPkg::opcLui, controlPkg::opcAuipc};
		rstN = 1'b0;
		insValid = 1'b0;
		insBits = 9'h000;
		brEq = 1'b0;
		brLt = 1'b0;
		repeat (10) @(negedge clk);
		rstN = 1'b1;
		repeat (3) begin
			rnd = $urandom;
			driveIns(1'b0, rnd[8:0], rnd[9], rnd[10]); // Noise while idle
		end
		endTest("reset and idle");
		sweepOpcode(controlPkg::opcR, 1'b0);
		sweepOpcode(controlPkg::opcI, 1'b0);
		endTest("R and I ALU");
		sweepOpcode(controlPkg::opcLoad, 1'b0);
		sweepOpcode(controlPkg::opcStore, 1'b0);
		endTest("loads and stores");
		sweepOpcode(controlPkg::opcBranch, 1'b1);
		sweepOpcode(controlPkg::opcJal, 1'b0);
		sweepOpcode(controlPkg::opcJalr, 1'b0);
		endTest("branches and jumps");
		sweepOpcode(controlPkg::opcLui, 1'b0);
		sweepOpcode(controlPkg::opcAuipc, 1'b0);
		for (int o = 0; o < 32; o++) begin
			known = 1'b0;
			foreach (knownOpc[i]) begin
				if (knownOpc[i] == o[4:0]) begin
					known = 1'b1;
				end
			end
			rnd = $urandom;
			if (!known) begin
				driveIns(1'b1, {rnd[8:5], o[4:0]}, rnd[1], rnd[0]);
			end
		end
		endTest("upper immediates and unknown opcodes");
		for (int n = 0; n < 2000; n++) begin
			rnd = $urandom;
			if ($urandom % 4 != 0) begin
				rnd[4:0] = knownOpc[$urandom % 9]; // Mostly real opcodes
			end
			driveIns($urandom % 4 != 0, rnd[8:0], rnd[9], rnd[10]);
		end
		endTest("random stream");
		checkValue("word count", wordsIn, wordsOut);
		$display("Tests %0d, checks %0d, errors %0d", testNum - 1, checkCount, errCount);
		if (errCount == 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

endmodule

//--- controlUnit.f
+incdir+testbench
verilog/controlPkg.sv
verilog/operandDecode.sv
verilog/memWbDecode.sv
verilog/branchResolve.sv
verilog/controlUnit.sv
testbench/controlUnitTb.sv
